// File: logic/dma_pkg.sv
/* DMA tile shared definitions */

package dma_pkg;

  //////////////////////////////////////////////////
  // NoC flit format

  localparam int FLIT_PAYLOAD_WIDTH = 32;
  localparam int FLIT_TYPE_WIDTH    = 2;
  localparam int FLIT_WIDTH         = FLIT_TYPE_WIDTH + FLIT_PAYLOAD_WIDTH;  // Type on top

  typedef enum logic [FLIT_TYPE_WIDTH-1:0] {
    FLIT_HEAD = 2'd0,
    FLIT_BODY = 2'd1,
    FLIT_LAST = 2'd2
  } flit_type_t;

  // Opcode sits in the head flit payload
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } noc_op_t;

  localparam int OP_BIT = 0;  // Payload bit of the opcode

  //////////////////////////////////////////////////
  // Config register map

  localparam logic [1:0] REG_SRC  = 2'd0;  // Source address
  localparam logic [1:0] REG_DST  = 2'd1;  // Destination address
  localparam logic [1:0] REG_LEN  = 2'd2;  // Length in words
  localparam logic [1:0] REG_CTRL = 2'd3;  // Valid and done

  localparam int CTRL_VALID_BIT = 0;
  localparam int CTRL_DONE_BIT  = 1;

  localparam int CFG_WORD_LSB  = 2;  // Word index in bits 3:2
  localparam int CFG_ENTRY_LSB = 4;  // Entry index above it

endpackage

// File: logic/dma_request_table.sv
/* DMA request table */

`timescale 1ns/1ns

module dma_request_table
  import dma_pkg::*;
#(
  parameter int ADDR_WIDTH    = 32,
  parameter int DATA_WIDTH    = 32,
  parameter int TABLE_ENTRIES = 4
) (
  input  logic                                   clk,
  input  logic                                   rst,
  // Config bus
  input  logic                                   cfg_en_i,
  input  logic                                   cfg_we_i,
  input  logic [ADDR_WIDTH-1:0]                  cfg_addr_i,
  input  logic [DATA_WIDTH-1:0]                  cfg_din_i,
  output logic [DATA_WIDTH-1:0]                  cfg_dout_o,
  // Completion from copy engine
  input  logic                                   done_en_i,
  input  logic [$clog2(TABLE_ENTRIES)-1:0]       done_pos_i,
  // Next pending entry
  output logic                                   pend_o,
  output logic [$clog2(TABLE_ENTRIES)-1:0]       pend_pos_o,
  output logic [ADDR_WIDTH-1:0]                  pend_src_o,
  output logic [ADDR_WIDTH-1:0]                  pend_dst_o,
  output logic [DATA_WIDTH-1:0]                  pend_len_o,
  output logic [TABLE_ENTRIES-1:0]               irq_o
);

  localparam int PTR_WIDTH = $clog2(TABLE_ENTRIES);

  logic [ADDR_WIDTH-1:0]    src_q [TABLE_ENTRIES];  // Entry payload, no reset
  logic [ADDR_WIDTH-1:0]    dst_q [TABLE_ENTRIES];
  logic [DATA_WIDTH-1:0]    len_q [TABLE_ENTRIES];
  logic [TABLE_ENTRIES-1:0] valid_q;
  logic [TABLE_ENTRIES-1:0] done_q;

  logic [PTR_WIDTH-1:0]     cfg_entry;
  logic [1:0]               cfg_word;
  logic [DATA_WIDTH-1:0]    ctrl_word;
  logic [PTR_WIDTH-1:0]     pick;

  assign cfg_entry = cfg_addr_i[CFG_ENTRY_LSB +: PTR_WIDTH];
  assign cfg_word  = cfg_addr_i[CFG_WORD_LSB +: 2];

  //////////////////////////////////////////////////
  // Config writes and completion

  always_ff @(posedge clk) begin
    if (cfg_en_i && cfg_we_i) begin
      case (cfg_word)
        REG_SRC: src_q[cfg_entry] <= ADDR_WIDTH'(cfg_din_i);
        REG_DST: dst_q[cfg_entry] <= ADDR_WIDTH'(cfg_din_i);
        REG_LEN: len_q[cfg_entry] <= cfg_din_i;
        default: ;                                         // CTRL handled below
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      if (done_en_i) begin                                 // Engine finished
        valid_q[done_pos_i] <= 1'b0;
        done_q[done_pos_i]  <= 1'b1;
      end
      if (cfg_en_i && cfg_we_i && cfg_word == REG_CTRL && cfg_din_i[CTRL_VALID_BIT]) begin
        valid_q[cfg_entry] <= 1'b1;                        // Arm entry
        done_q[cfg_entry]  <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Config read, one cycle

  always_comb begin
    ctrl_word                 = '0;
    ctrl_word[CTRL_VALID_BIT] = valid_q[cfg_entry];
    ctrl_word[CTRL_DONE_BIT]  = done_q[cfg_entry];
  end

  always_ff @(posedge clk) begin
    if (cfg_en_i && !cfg_we_i) begin                       // Holds until next read
      case (cfg_word)
        REG_SRC: cfg_dout_o <= DATA_WIDTH'(src_q[cfg_entry]);
        REG_DST: cfg_dout_o <= DATA_WIDTH'(dst_q[cfg_entry]);
        REG_LEN: cfg_dout_o <= len_q[cfg_entry];
        default: cfg_dout_o <= ctrl_word;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Lowest valid index wins

  always_comb begin
    pick = '0;
    for (int i = TABLE_ENTRIES - 1; i >= 0; i--) begin
      if (valid_q[i]) pick = PTR_WIDTH'(i);
    end
  end

  assign pend_o     = |valid_q;
  assign pend_pos_o = pick;
  assign pend_src_o = src_q[pick];
  assign pend_dst_o = dst_q[pick];
  assign pend_len_o = len_q[pick];
  assign irq_o      = done_q;                              // Done vector is the interrupt

  // Engine only ever completes an entry it picked up while armed
  a_done_valid: assert property (@(posedge clk) disable iff (rst)
    done_en_i |-> valid_q[done_pos_i]);

endmodule

// File: logic/dma_copy_engine.sv
/* Local memory copy engine */

`timescale 1ns/1ns

module dma_copy_engine #(
  parameter int ADDR_WIDTH    = 32,
  parameter int DATA_WIDTH    = 32,
  parameter int TABLE_ENTRIES = 4
) (
  input  logic                             clk,
  input  logic                             rst,
  // Pending entry from table
  input  logic                             pend_i,
  input  logic [$clog2(TABLE_ENTRIES)-1:0] pend_pos_i,
  input  logic [ADDR_WIDTH-1:0]            pend_src_i,
  input  logic [ADDR_WIDTH-1:0]            pend_dst_i,
  input  logic [DATA_WIDTH-1:0]            pend_len_i,
  output logic                             done_en_o,
  output logic [$clog2(TABLE_ENTRIES)-1:0] done_pos_o,
  // Memory bus master
  output logic                             bus_en_o,
  output logic                             bus_we_o,
  output logic [ADDR_WIDTH-1:0]            bus_addr_o,
  output logic [DATA_WIDTH-1:0]            bus_din_o,
  input  logic                             bus_gnt_i,
  input  logic [DATA_WIDTH-1:0]            bus_dout_i
);

  localparam int PTR_WIDTH  = $clog2(TABLE_ENTRIES);
  localparam int WORD_BYTES = DATA_WIDTH / 8;              // Byte step per word

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ,
    ST_CAPTURE,
    ST_WRITE,
    ST_DONE
  } state_t;

  state_t                state_q;
  logic                  rearm_q;                          // One idle cycle after done
  logic [PTR_WIDTH-1:0]  pos_q;
  logic [ADDR_WIDTH-1:0] src_q;
  logic [ADDR_WIDTH-1:0] dst_q;
  logic [DATA_WIDTH-1:0] cnt_q;                            // Words left
  logic [DATA_WIDTH-1:0] data_q;

  //////////////////////////////////////////////////
  // FSM

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      rearm_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          rearm_q <= 1'b0;
          if (pend_i && !rearm_q) begin                    // Table has dropped old entry
            state_q <= (pend_len_i == '0) ? ST_DONE : ST_READ;
          end
        end
        ST_READ:    if (bus_gnt_i) state_q <= ST_CAPTURE;
        ST_CAPTURE: state_q <= ST_WRITE;                   // Bus released here
        ST_WRITE: begin
          if (bus_gnt_i) begin
            state_q <= (cnt_q == DATA_WIDTH'(1)) ? ST_DONE : ST_READ;
          end
        end
        default: begin                                     // ST_DONE
          state_q <= ST_IDLE;
          rearm_q <= 1'b1;
        end
      endcase
    end
  end

  // Working registers
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE) begin                          // Latch entry
      pos_q <= pend_pos_i;
      src_q <= pend_src_i;
      dst_q <= pend_dst_i;
      cnt_q <= pend_len_i;
    end
    if (state_q == ST_CAPTURE) data_q <= bus_dout_i;       // Read data lands here
    if (state_q == ST_WRITE && bus_gnt_i) begin
      src_q <= src_q + ADDR_WIDTH'(WORD_BYTES);
      dst_q <= dst_q + ADDR_WIDTH'(WORD_BYTES);
      cnt_q <= cnt_q - DATA_WIDTH'(1);
    end
  end

  //////////////////////////////////////////////////
  // Outputs

  assign bus_en_o   = (state_q == ST_READ) || (state_q == ST_WRITE);
  assign bus_we_o   = (state_q == ST_WRITE);
  assign bus_addr_o = (state_q == ST_WRITE) ? dst_q : src_q;
  assign bus_din_o  = data_q;
  assign done_en_o  = (state_q == ST_DONE);                // Single cycle pulse
  assign done_pos_o = pos_q;

  // Request stays put until the arbiter grants it
  a_hold_req: assert property (@(posedge clk) disable iff (rst)
    (bus_en_o && !bus_gnt_i) |=> bus_en_o && $stable(bus_we_o) && $stable(bus_addr_o)
                                 && $stable(bus_din_o));

endmodule

// File: logic/dma_noc_target.sv
/* NoC target for remote access */

`timescale 1ns/1ns

module dma_noc_target
  import dma_pkg::*;
#(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  // Request packets in
  input  logic [FLIT_WIDTH-1:0] noc_in_flit_i,
  input  logic                  noc_in_valid_i,
  output logic                  noc_in_ready_o,
  // Read responses out
  output logic [FLIT_WIDTH-1:0] noc_out_flit_o,
  output logic                  noc_out_valid_o,
  input  logic                  noc_out_ready_i,
  // Memory bus master
  output logic                  bus_en_o,
  output logic                  bus_we_o,
  output logic [ADDR_WIDTH-1:0] bus_addr_o,
  output logic [DATA_WIDTH-1:0] bus_din_o,
  input  logic                  bus_gnt_i,
  input  logic [DATA_WIDTH-1:0] bus_dout_i
);

  typedef enum logic [2:0] {
    T_HEAD,
    T_ADDR,
    T_DATA,
    T_ACCESS,
    T_RESP
  } state_t;

  state_t                state_q;
  noc_op_t               op_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [DATA_WIDTH-1:0] wdata_q;
  logic [DATA_WIDTH-1:0] rdata_q;                          // Held response word
  logic                  fresh_q;                          // First response cycle
  logic [DATA_WIDTH-1:0] rdata;
  logic                  in_xfer;
  flit_type_t            in_type;

  assign in_xfer = noc_in_valid_i && noc_in_ready_o;
  assign in_type = flit_type_t'(noc_in_flit_i[FLIT_WIDTH-1 -: FLIT_TYPE_WIDTH]);

  //////////////////////////////////////////////////
  // Packet parser and access sequence

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= T_HEAD;
      fresh_q <= 1'b0;
    end else begin
      fresh_q <= (state_q == T_ACCESS) && bus_gnt_i && (op_q == OP_READ);
      case (state_q)
        T_HEAD: if (in_xfer) state_q <= T_ADDR;
        T_ADDR: if (in_xfer) state_q <= (op_q == OP_WRITE) ? T_DATA : T_ACCESS;
        T_DATA: if (in_xfer) state_q <= T_ACCESS;
        T_ACCESS: begin
          if (bus_gnt_i) state_q <= (op_q == OP_WRITE) ? T_HEAD : T_RESP;  // Writes silent
        end
        default: if (noc_out_ready_i) state_q <= T_HEAD;   // T_RESP
      endcase
    end
  end

  // Packet fields, no reset
  always_ff @(posedge clk) begin
    if (in_xfer) begin
      case (state_q)
        T_HEAD:  op_q    <= noc_op_t'(noc_in_flit_i[OP_BIT]);
        T_ADDR:  addr_q  <= noc_in_flit_i[ADDR_WIDTH-1:0];
        default: wdata_q <= noc_in_flit_i[DATA_WIDTH-1:0];
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Response flit

  // Bus data goes straight out in the first cycle, register holds it after
  assign rdata = fresh_q ? bus_dout_i : rdata_q;

  always_ff @(posedge clk) begin
    if (state_q == T_RESP) rdata_q <= rdata;
  end

  assign noc_out_flit_o  = {FLIT_LAST, rdata};
  assign noc_out_valid_o = (state_q == T_RESP);
  assign noc_in_ready_o  = (state_q == T_HEAD) || (state_q == T_ADDR) || (state_q == T_DATA);

  assign bus_en_o   = (state_q == T_ACCESS);
  assign bus_we_o   = (op_q == OP_WRITE);
  assign bus_addr_o = addr_q;
  assign bus_din_o  = wdata_q;

  // Senders keep packets aligned
  a_head_first: assert property (@(posedge clk) disable iff (rst)
    (state_q == T_HEAD && noc_in_valid_i) |-> (in_type == FLIT_HEAD));

endmodule

// File: logic/bb_port_arbiter.sv
/* Memory port arbiter */

`timescale 1ns/1ns

module bb_port_arbiter #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  // NoC target master, high priority
  input  logic                  tgt_en_i,
  input  logic                  tgt_we_i,
  input  logic [ADDR_WIDTH-1:0] tgt_addr_i,
  input  logic [DATA_WIDTH-1:0] tgt_din_i,
  output logic                  tgt_gnt_o,
  // Copy engine master
  input  logic                  eng_en_i,
  input  logic                  eng_we_i,
  input  logic [ADDR_WIDTH-1:0] eng_addr_i,
  input  logic [DATA_WIDTH-1:0] eng_din_i,
  output logic                  eng_gnt_o,
  // Memory bus
  output logic                  mem_en_o,
  output logic                  mem_we_o,
  output logic [ADDR_WIDTH-1:0] mem_addr_o,
  output logic [DATA_WIDTH-1:0] mem_din_o
);

  localparam logic OWN_TGT = 1'b0;
  localparam logic OWN_ENG = 1'b1;

  logic owner_q;
  logic owner_nxt;
  logic owner_active;                                      // Owner still requesting

  assign owner_active = (owner_q == OWN_TGT) ? tgt_en_i : eng_en_i;

  always_comb begin
    if (owner_active)  owner_nxt = owner_q;                // Sticky
    else if (tgt_en_i) owner_nxt = OWN_TGT;
    else if (eng_en_i) owner_nxt = OWN_ENG;
    else               owner_nxt = OWN_TGT;                // Park on target
  end

  always_ff @(posedge clk) begin
    if (rst) owner_q <= OWN_TGT;
    else     owner_q <= owner_nxt;
  end

  //////////////////////////////////////////////////
  // Grants and request mux

  assign tgt_gnt_o = (owner_q == OWN_TGT) && tgt_en_i;
  assign eng_gnt_o = (owner_q == OWN_ENG) && eng_en_i;

  assign mem_en_o   = owner_active;
  assign mem_we_o   = (owner_q == OWN_TGT) ? tgt_we_i   : eng_we_i;
  assign mem_addr_o = (owner_q == OWN_TGT) ? tgt_addr_i : eng_addr_i;
  assign mem_din_o  = (owner_q == OWN_TGT) ? tgt_din_i  : eng_din_i;

  // Waiting master gets the bus one cycle after the other side goes quiet
  a_tgt_handoff: assert property (@(posedge clk) disable iff (rst)
    (tgt_en_i && !tgt_gnt_o && !eng_en_i) |=> tgt_gnt_o);
  a_eng_handoff: assert property (@(posedge clk) disable iff (rst)
    (eng_en_i && !eng_gnt_o && !tgt_en_i) |=> eng_gnt_o);

endmodule

// File: logic/dma_tile_top.sv
/* DMA tile memory port subsystem */

`timescale 1ns/1ns

module dma_tile_top
  import dma_pkg::*;
#(
  parameter int ADDR_WIDTH    = 32,
  parameter int DATA_WIDTH    = 32,
  parameter int TABLE_ENTRIES = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  // Config bus
  input  logic                     cfg_en_i,
  input  logic                     cfg_we_i,
  input  logic [ADDR_WIDTH-1:0]    cfg_addr_i,
  input  logic [DATA_WIDTH-1:0]    cfg_din_i,
  output logic [DATA_WIDTH-1:0]    cfg_dout_o,
  // NoC
  input  logic [FLIT_WIDTH-1:0]    noc_in_flit_i,
  input  logic                     noc_in_valid_i,
  output logic                     noc_in_ready_o,
  output logic [FLIT_WIDTH-1:0]    noc_out_flit_o,
  output logic                     noc_out_valid_o,
  input  logic                     noc_out_ready_i,
  // Memory bus
  output logic                     mem_en_o,
  output logic                     mem_we_o,
  output logic [ADDR_WIDTH-1:0]    mem_addr_o,
  output logic [DATA_WIDTH-1:0]    mem_din_o,
  input  logic [DATA_WIDTH-1:0]    mem_dout_i,
  output logic [TABLE_ENTRIES-1:0] irq_o
);

  localparam int PTR_WIDTH = $clog2(TABLE_ENTRIES);

  // Table to engine
  logic                  pend;
  logic [PTR_WIDTH-1:0]  pend_pos;
  logic [ADDR_WIDTH-1:0] pend_src;
  logic [ADDR_WIDTH-1:0] pend_dst;
  logic [DATA_WIDTH-1:0] pend_len;
  logic                  done_en;
  logic [PTR_WIDTH-1:0]  done_pos;

  // Masters to arbiter
  logic                  eng_en, eng_we, eng_gnt;
  logic [ADDR_WIDTH-1:0] eng_addr;
  logic [DATA_WIDTH-1:0] eng_din;
  logic                  tgt_en, tgt_we, tgt_gnt;
  logic [ADDR_WIDTH-1:0] tgt_addr;
  logic [DATA_WIDTH-1:0] tgt_din;

  dma_request_table #(
    .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .TABLE_ENTRIES(TABLE_ENTRIES)
  ) dma_request_table_i (
    .clk, .rst, .cfg_en_i, .cfg_we_i, .cfg_addr_i, .cfg_din_i, .cfg_dout_o,
    .done_en_i(done_en), .done_pos_i(done_pos),
    .pend_o(pend), .pend_pos_o(pend_pos), .pend_src_o(pend_src),
    .pend_dst_o(pend_dst), .pend_len_o(pend_len), .irq_o
  );

  dma_copy_engine #(
    .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .TABLE_ENTRIES(TABLE_ENTRIES)
  ) dma_copy_engine_i (
    .clk, .rst,
    .pend_i(pend), .pend_pos_i(pend_pos), .pend_src_i(pend_src),
    .pend_dst_i(pend_dst), .pend_len_i(pend_len),
    .done_en_o(done_en), .done_pos_o(done_pos),
    .bus_en_o(eng_en), .bus_we_o(eng_we), .bus_addr_o(eng_addr), .bus_din_o(eng_din),
    .bus_gnt_i(eng_gnt), .bus_dout_i(mem_dout_i)           // Read data shared
  );

  dma_noc_target #(
    .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)
  ) dma_noc_target_i (
    .clk, .rst, .noc_in_flit_i, .noc_in_valid_i, .noc_in_ready_o,
    .noc_out_flit_o, .noc_out_valid_o, .noc_out_ready_i,
    .bus_en_o(tgt_en), .bus_we_o(tgt_we), .bus_addr_o(tgt_addr), .bus_din_o(tgt_din),
    .bus_gnt_i(tgt_gnt), .bus_dout_i(mem_dout_i)
  );

  bb_port_arbiter #(
    .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)
  ) bb_port_arbiter_i (
    .clk, .rst,
    .tgt_en_i(tgt_en), .tgt_we_i(tgt_we), .tgt_addr_i(tgt_addr), .tgt_din_i(tgt_din),
    .tgt_gnt_o(tgt_gnt),
    .eng_en_i(eng_en), .eng_we_i(eng_we), .eng_addr_i(eng_addr), .eng_din_i(eng_din),
    .eng_gnt_o(eng_gnt),
    .mem_en_o, .mem_we_o, .mem_addr_o, .mem_din_o
  );

endmodule

// File: bench/bb_mem_model.sv
/* Word RAM for the bench */

`timescale 1ns/1ns

module bb_mem_model #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32,
  parameter int MEM_WORDS  = 1024
) (
  input  logic                  clk,
  input  logic                  en_i,
  input  logic                  we_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,                    // Byte address
  input  logic [DATA_WIDTH-1:0] din_i,
  output logic [DATA_WIDTH-1:0] dout_o
);

  localparam int IDX_WIDTH = $clog2(MEM_WORDS);

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];                  // Backdoor array
  logic [IDX_WIDTH-1:0]  idx;

  assign idx = addr_i[IDX_WIDTH+1:2];                      // Word index

  // One cycle read latency, dout holds until the next read
  always @(posedge clk) begin
    if (en_i) begin
      if (we_i) mem[idx] <= din_i;
      else      dout_o   <= mem[idx];
    end
  end

endmodule

// File: bench/dma_tile_tb.sv
/* DMA tile testbench */

`timescale 1ns/1ns

module dma_tile_tb
  import dma_pkg::*;
();

  localparam int ADDR_WIDTH    = 32;
  localparam int DATA_WIDTH    = 32;
  localparam int TABLE_ENTRIES = 4;
  localparam int MEM_WORDS     = 1024;
  localparam int RESET_CYCLES  = 5;
  localparam logic [31:0] SEED = 32'h5b01;

  // Cycle budget per test step
  localparam int CFG_OPS       = 90;                       // Config accesses, 2 cycles each
  localparam int COPY_WORDS    = 55;                       // 8 + 4 + 5 + 6 + 32
  localparam int WORD_CYCLES   = 8;                        // Read, capture, write, stolen slots
  localparam int NOC_OPS       = 14;
  localparam int NOC_OP_CYCLES = 24;                       // Flits, access, back-pressure
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + 2 * CFG_OPS
                                     + COPY_WORDS * WORD_CYCLES + NOC_OPS * NOC_OP_CYCLES);

  logic                     clk;
  logic                     rst;
  logic                     cfg_en;
  logic                     cfg_we;
  logic [ADDR_WIDTH-1:0]    cfg_addr;
  logic [DATA_WIDTH-1:0]    cfg_din;
  logic [DATA_WIDTH-1:0]    cfg_dout;
  logic [FLIT_WIDTH-1:0]    noc_in_flit;
  logic                     noc_in_valid;
  logic                     noc_in_ready;
  logic [FLIT_WIDTH-1:0]    noc_out_flit;
  logic                     noc_out_valid;
  logic                     noc_out_ready;
  logic                     mem_en;
  logic                     mem_we;
  logic [ADDR_WIDTH-1:0]    mem_addr;
  logic [DATA_WIDTH-1:0]    mem_din;
  logic [DATA_WIDTH-1:0]    mem_dout;
  logic [TABLE_ENTRIES-1:0] irq;

  logic [DATA_WIDTH-1:0]    exp_mem [MEM_WORDS];           // Reference memory image
  logic [31:0]              lfsr_q;
  int                       error_cnt;
  int                       cycle_cnt;

  dma_tile_top #(
    .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .TABLE_ENTRIES(TABLE_ENTRIES)
  ) dma_tile_top_i (
    .clk(clk), .rst(rst),
    .cfg_en_i(cfg_en), .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr),
    .cfg_din_i(cfg_din), .cfg_dout_o(cfg_dout),
    .noc_in_flit_i(noc_in_flit), .noc_in_valid_i(noc_in_valid),
    .noc_in_ready_o(noc_in_ready),
    .noc_out_flit_o(noc_out_flit), .noc_out_valid_o(noc_out_valid),
    .noc_out_ready_i(noc_out_ready),
    .mem_en_o(mem_en), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
    .mem_din_o(mem_din), .mem_dout_i(mem_dout), .irq_o(irq)
  );

  bb_mem_model #(
    .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .MEM_WORDS(MEM_WORDS)
  ) mem_model_i (
    .clk(clk), .en_i(mem_en), .we_i(mem_we), .addr_i(mem_addr),
    .din_i(mem_din), .dout_o(mem_dout)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;                                // 100 ns period
  end

  //////////////////////////////////////////////////
  // Helpers

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);                          // One step per bit
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  function automatic int word_idx(input logic [31:0] addr);
    return int'(addr >> 2) % MEM_WORDS;
  endfunction

  function automatic logic [31:0] cfg_addr_of(input int entry, input int word);
    return (32'(entry) << CFG_ENTRY_LSB) | (32'(word) << CFG_WORD_LSB);
  endfunction

  task automatic check_value(input string test_name, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    assert (actual === expected) else begin
      error_cnt++;
      $display("FAILED %s (%s): expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  // Whole array against the reference image
  task automatic check_memory(input string test_name);
    int bad;
    int first;
    bad   = 0;
    first = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (mem_model_i.mem[i] !== exp_mem[i]) begin
        if (bad == 0) first = i;
        bad++;
      end
    end
    assert (bad == 0) else begin
      error_cnt++;
      $display("FAILED %s (memory word %0d, %0d words differ): expected %0h, actual %0h",
               test_name, first, bad, exp_mem[first], mem_model_i.mem[first]);
    end
  endtask

  task automatic fill_memory();
    logic [31:0] w;
    for (int i = 0; i < MEM_WORDS; i++) begin
      rand_bits(32, w);
      mem_model_i.mem[i] = w;
      exp_mem[i]         = w;
    end
  endtask

  // All bus tasks start and end on a falling edge
  task automatic cfg_write(input logic [31:0] addr, input logic [31:0] data);
    cfg_en   = 1'b1;
    cfg_we   = 1'b1;
    cfg_addr = addr;
    cfg_din  = data;
    @(negedge clk);
    cfg_en   = 1'b0;
    cfg_we   = 1'b0;
  endtask

  task automatic cfg_read(input logic [31:0] addr, output logic [31:0] data);
    cfg_en   = 1'b1;
    cfg_we   = 1'b0;
    cfg_addr = addr;
    @(negedge clk);
    cfg_en   = 1'b0;
    data     = cfg_dout;                                   // Registered one cycle on
  endtask

  task automatic program_entry(input int entry, input logic [31:0] src,
                               input logic [31:0] dst, input logic [31:0] len);
    int s;
    int d;
    s = word_idx(src);
    d = word_idx(dst);
    for (int i = 0; i < int'(len); i++) exp_mem[(d + i) % MEM_WORDS] = exp_mem[(s + i) % MEM_WORDS];
    cfg_write(cfg_addr_of(entry, REG_SRC), src);
    cfg_write(cfg_addr_of(entry, REG_DST), dst);
    cfg_write(cfg_addr_of(entry, REG_LEN), len);
    cfg_write(cfg_addr_of(entry, REG_CTRL), 32'(1) << CTRL_VALID_BIT);  // Arm
  endtask

  task automatic wait_irq(input logic [TABLE_ENTRIES-1:0] mask);
    while ((irq & mask) != mask) @(negedge clk);           // Timeout guards this
  endtask

  task automatic check_done(input string test_name, input int entry);
    logic [31:0] rd;
    cfg_read(cfg_addr_of(entry, REG_CTRL), rd);
    check_value(test_name, $sformatf("ctrl word of entry %0d", entry),
                32'(1) << CTRL_DONE_BIT, rd);
  endtask

  task automatic send_flit(input flit_type_t kind, input logic [31:0] payload);
    noc_in_flit  = {kind, payload};
    noc_in_valid = 1'b1;
    while (!noc_in_ready) @(negedge clk);
    @(negedge clk);                                        // Taken at the rising edge
    noc_in_valid = 1'b0;
  endtask

  task automatic noc_write(input logic [31:0] addr, input logic [31:0] data);
    send_flit(FLIT_HEAD, 32'(OP_WRITE) << OP_BIT);
    send_flit(FLIT_BODY, addr);
    send_flit(FLIT_LAST, data);
    exp_mem[word_idx(addr)] = data;
  endtask

  // Read with random back-pressure on the response
  task automatic noc_read(input string test_name, input logic [31:0] addr);
    logic [FLIT_WIDTH-1:0] held;
    logic [31:0]           hold;
    send_flit(FLIT_HEAD, 32'(OP_READ) << OP_BIT);
    send_flit(FLIT_LAST, addr);
    while (!noc_out_valid) @(negedge clk);
    held = noc_out_flit;
    check_value(test_name, "response flit type", FLIT_LAST,
                held[FLIT_WIDTH-1 -: FLIT_TYPE_WIDTH]);
    check_value(test_name, $sformatf("read data at %0h", addr),
                exp_mem[word_idx(addr)], held[DATA_WIDTH-1:0]);
    rand_bits(3, hold);
    repeat (hold + 1) begin
      @(negedge clk);
      check_value(test_name, "valid under back-pressure", 1, noc_out_valid);
      check_value(test_name, "flit under back-pressure", held, noc_out_flit);
    end
    noc_out_ready = 1'b1;
    @(negedge clk);
    noc_out_ready = 1'b0;
    check_value(test_name, "single response flit", 0, noc_out_valid);
  endtask

  //////////////////////////////////////////////////
  // Directed tests

  task automatic test_reset_config();
    logic [31:0] vals [TABLE_ENTRIES][3];
    logic [31:0] rd;
    check_value("reset_config", "noc_in_ready", 1, noc_in_ready);
    check_value("reset_config", "noc_out_valid", 0, noc_out_valid);
    check_value("reset_config", "mem_en", 0, mem_en);
    check_value("reset_config", "irq", 0, irq);
    for (int e = 0; e < TABLE_ENTRIES; e++) begin
      for (int w = 0; w < 3; w++) begin                    // SRC, DST, LEN
        rand_bits(32, vals[e][w]);
        cfg_write(cfg_addr_of(e, w), vals[e][w]);
        cfg_read(cfg_addr_of(e, w), rd);
        check_value("reset_config", $sformatf("entry %0d word %0d", e, w), vals[e][w], rd);
      end
    end
    // Second pass catches aliasing between entries
    for (int e = 0; e < TABLE_ENTRIES; e++) begin
      for (int w = 0; w < 3; w++) begin
        cfg_read(cfg_addr_of(e, w), rd);
        check_value("reset_config", $sformatf("reread %0d/%0d", e, w), vals[e][w], rd);
      end
    end
  endtask

  task automatic test_single_copy();
    program_entry(0, 32'h100, 32'h400, 8);
    wait_irq(4'b0001);
    check_memory("single_copy");
    check_done("single_copy", 0);
  endtask

  task automatic test_reverse_order();
    for (int e = 2; e >= 0; e--) begin
      program_entry(e, 32'h200 + 32'(e) * 32'h40, 32'h600 + 32'(e) * 32'h40, 32'(4 + e));
    end
    wait_irq(4'b0111);
    check_memory("reverse_order");
    for (int e = 0; e < 3; e++) check_done("reverse_order", e);
  endtask

  task automatic test_noc_write_read();
    logic [31:0] d;
    rand_bits(32, d);
    noc_write(32'h800, d);
    noc_read("noc_write_read", 32'h800);
    check_memory("noc_write_read");
  endtask

  // NoC traffic in its own region while entry 3 copies
  task automatic test_copy_with_noc();
    logic [31:0] d;
    logic [31:0] a;
    program_entry(3, 32'h900, 32'hA00, 32);
    for (int i = 0; i < 4; i++) begin
      a = 32'hC00 + 32'(i) * 4;
      rand_bits(32, d);
      noc_write(a, d);
      if (i == 0) check_value("copy_with_noc", "copy still running", 0, irq[3]);
      noc_read("copy_with_noc", a);
      noc_read("copy_with_noc", a + 32'h40);               // Untouched word
    end
    wait_irq(4'b1000);
    check_memory("copy_with_noc");
    check_done("copy_with_noc", 3);
  endtask

  //////////////////////////////////////////////////
  // Sequence and timeout

  initial begin
    rst           = 1'b1;
    cfg_en        = 1'b0;
    cfg_we        = 1'b0;
    cfg_addr      = '0;
    cfg_din       = '0;
    noc_in_flit   = '0;
    noc_in_valid  = 1'b0;
    noc_out_ready = 1'b0;
    error_cnt     = 0;
    lfsr_q        = SEED;
    fill_memory();
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    test_reset_config();
    test_single_copy();
    test_reverse_order();
    test_noc_write_read();
    test_copy_with_noc();
    $display("Summary: %0d errors after %0d cycles", error_cnt, cycle_cnt);
    if (error_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: list.f
logic/dma_pkg.sv
logic/dma_request_table.sv
logic/dma_copy_engine.sv
logic/dma_noc_target.sv
logic/bb_port_arbiter.sv
logic/dma_tile_top.sv
bench/bb_mem_model.sv
bench/dma_tile_tb.sv

// File: Bender.yml
package:
  name: dma_tile

sources:
  # RTL
  - logic/dma_pkg.sv
  - logic/dma_request_table.sv
  - logic/dma_copy_engine.sv
  - logic/dma_noc_target.sv
  - logic/bb_port_arbiter.sv
  - logic/dma_tile_top.sv
  # Bench
  - target: simulation
    files:
      - bench/bb_mem_model.sv
      - bench/dma_tile_tb.sv
